/* sdh_settings.svh */
`ifndef SDH_SETTINGS_SVH
`define SDH_SETTINGS_SVH

// Wishbone word and register address
`define SDH_DATA_W 32
`define SDH_ADR_W 32

// Block size and byte count fields
`define SDH_BLK_W 24

// Functions 0 to 7 plus memory
`define SDH_NUM_BLK 9

// PHY delay line tap
`define SDH_DELAY_W 8

// Tap the delay line sits at out of reset
`define SDH_INITIAL_DELAY 8'd16

// Idle cycles the stack waits between blocks
`define SDH_DEFAULT_BLOCK_SLEEP 32'd1

`endif

/* sdh_reg_pkg.sv */
`include "sdh_settings.svh"

package sdh_reg_pkg;

  // Wishbone register map, word addressed
  typedef enum logic [`SDH_ADR_W-1:0] {
    CONTROL            = 'h00,
    STATUS             = 'h01,
    SD_ARGUMENT        = 'h06,
    SD_COMMAND         = 'h07,
    SD_CONFIGURE       = 'h08,
    SD_RESPONSE0       = 'h09,
    SD_RESPONSE1       = 'h0A,
    SD_RESPONSE2       = 'h0B,
    SD_RESPONSE3       = 'h0C,
    SD_DATA_BYTE_COUNT = 'h0D,
    SD_BLOCK_SLEEP     = 'h0E,
    SD_F0_BLOCK_SIZE   = 'h10,
    SD_F1_BLOCK_SIZE   = 'h11,
    SD_F2_BLOCK_SIZE   = 'h12,
    SD_F3_BLOCK_SIZE   = 'h13,
    SD_F4_BLOCK_SIZE   = 'h14,
    SD_F5_BLOCK_SIZE   = 'h15,
    SD_F6_BLOCK_SIZE   = 'h16,
    SD_F7_BLOCK_SIZE   = 'h17,
    SD_MEM_BLOCK_SIZE  = 'h18,
    SD_DELAY_VALUE     = 'h22
  } reg_addr_e;

  // Bit 0 is enable_sd, bit 7 is data_activate
  typedef struct packed {
    logic [23:0] reserved;
    logic        data_activate;
    logic [2:0]  func_addr;
    logic        data_block_mode;
    logic        data_write;
    logic        enable_interrupt;
    logic        enable_sd;
  } control_t;

  // Go reads back as the live command enable
  typedef struct packed {
    logic [23:0] reserved;
    logic        go;
    logic        long_flag;
    logic [5:0]  cmd_index;
  } command_t;

  typedef struct packed {
    logic [19:0] reserved;
    logic [7:0]  error;
    logic        sd_ready;
    logic        data_busy;
    logic        sd_busy;
    logic        enable;
  } status_t;

endpackage

/* sdh_stack_pkg.sv */
`include "sdh_settings.svh"

package sdh_stack_pkg;

  // Wrapper to SD protocol stack
  typedef struct packed {
    logic                                    cmd_en;
    logic [5:0]                              cmd_index;
    logic [31:0]                             cmd_arg;
    logic                                    cmd_long;
    logic                                    crc_en;
    logic                                    data_activate;
    logic                                    data_write;
    logic                                    data_block_mode;
    logic [2:0]                              func_addr;
    logic [`SDH_BLK_W-1:0]                   byte_count;
    logic [`SDH_DATA_W-1:0]                  block_sleep;
    // Index 8 is the memory block size
    logic [`SDH_NUM_BLK-1:0][`SDH_BLK_W-1:0] block_size;
  } stack_req_t;

  // Stack back to wrapper
  // Finished and interrupt flags are one-cycle pulses
  typedef struct packed {
    logic         ready;
    logic [7:0]   error;
    logic         cmd_finished;
    logic         data_finished;
    logic         int_detected;
    logic [127:0] rsp;
  } stack_stat_t;

  // PHY delay line control
  typedef struct packed {
    logic en;
    logic inc;
  } delay_step_t;

endpackage

/* sdh_reg_file.sv */
`include "sdh_settings.svh"

module sdh_reg_file (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_wbs_cyc,
  input  logic                        i_wbs_stb,
  input  logic                        i_wbs_we,
  input  logic [`SDH_ADR_W-1:0]       i_wbs_adr,
  input  logic [`SDH_DATA_W-1:0]      i_wbs_dat,
  input  sdh_stack_pkg::stack_stat_t  i_stack_stat,
  output logic                        o_wbs_ack,
  output logic [`SDH_DATA_W-1:0]      o_wbs_dat,
  output sdh_stack_pkg::stack_req_t   o_stack_req,
  output sdh_reg_pkg::control_t       o_control,
  output logic                        o_status_read,
  output logic [`SDH_DELAY_W-1:0]     o_delay_target
);

  localparam int BLK_IDX_W = $clog2(`SDH_NUM_BLK);

  sdh_reg_pkg::control_t                   r_control;
  sdh_reg_pkg::command_t                   r_command;
  sdh_reg_pkg::status_t                    w_status;
  logic [`SDH_DATA_W-1:0]                  r_cmd_arg;
  logic                                    r_crc_en;
  logic [`SDH_BLK_W-1:0]                   r_byte_count;
  logic [`SDH_DATA_W-1:0]                  r_block_sleep;
  logic [`SDH_NUM_BLK-1:0][`SDH_BLK_W-1:0] r_blk_size;
  logic [`SDH_DELAY_W-1:0]                 r_delay_target;
  logic [`SDH_DATA_W-1:0]                  w_rd_data;
  logic [`SDH_ADR_W-1:0]                   w_blk_off;
  logic [BLK_IDX_W-1:0]                    w_blk_idx;
  logic                                    w_blk_hit;
  logic                                    w_access;
  logic                                    w_write;
  logic                                    w_read;

  // New access only while ack is low
  assign w_access = i_wbs_stb && i_wbs_cyc && !o_wbs_ack;
  assign w_write  = w_access && i_wbs_we;
  assign w_read   = w_access && !i_wbs_we;

  // Nine block size registers sit on consecutive addresses
  assign w_blk_off = i_wbs_adr - sdh_reg_pkg::SD_F0_BLOCK_SIZE;
  assign w_blk_idx = w_blk_off[BLK_IDX_W-1:0];
  assign w_blk_hit = (i_wbs_adr >= sdh_reg_pkg::SD_F0_BLOCK_SIZE) &&
                     (i_wbs_adr <= sdh_reg_pkg::SD_MEM_BLOCK_SIZE);

  always_comb begin
    w_status           = '0;
    w_status.enable    = r_control.enable_sd;
    w_status.sd_busy   = r_command.go;
    w_status.data_busy = r_control.data_activate;
    w_status.sd_ready  = i_stack_stat.ready;
    w_status.error     = i_stack_stat.error;
  end

  // Read mux
  always_comb begin
    w_rd_data = '0;
    case (i_wbs_adr)
      sdh_reg_pkg::CONTROL:            w_rd_data = r_control;
      sdh_reg_pkg::STATUS:             w_rd_data = w_status;
      sdh_reg_pkg::SD_ARGUMENT:        w_rd_data = r_cmd_arg;
      sdh_reg_pkg::SD_COMMAND:         w_rd_data = r_command;
      sdh_reg_pkg::SD_CONFIGURE:       w_rd_data = `SDH_DATA_W'(r_crc_en);
      // Word 0 is the top of the response
      sdh_reg_pkg::SD_RESPONSE0:       w_rd_data = i_stack_stat.rsp[127:96];
      sdh_reg_pkg::SD_RESPONSE1:       w_rd_data = i_stack_stat.rsp[95:64];
      sdh_reg_pkg::SD_RESPONSE2:       w_rd_data = i_stack_stat.rsp[63:32];
      sdh_reg_pkg::SD_RESPONSE3:       w_rd_data = i_stack_stat.rsp[31:0];
      sdh_reg_pkg::SD_DATA_BYTE_COUNT: w_rd_data = `SDH_DATA_W'(r_byte_count);
      sdh_reg_pkg::SD_BLOCK_SLEEP:     w_rd_data = r_block_sleep;
      sdh_reg_pkg::SD_DELAY_VALUE:     w_rd_data = `SDH_DATA_W'(r_delay_target);
      default: begin
        if (w_blk_hit) begin
          w_rd_data = `SDH_DATA_W'(r_blk_size[w_blk_idx]);
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wbs_ack      <= 1'b0;
      o_status_read  <= 1'b0;
      r_control      <= '0;
      r_command      <= '0;
      r_cmd_arg      <= '0;
      r_crc_en       <= 1'b1;
      r_byte_count   <= '0;
      r_block_sleep  <= `SDH_DEFAULT_BLOCK_SLEEP;
      r_blk_size     <= '0;
      r_delay_target <= `SDH_INITIAL_DELAY;
    end else begin
      o_status_read <= w_read && (i_wbs_adr == sdh_reg_pkg::STATUS);

      // Master dropped strobe
      if (o_wbs_ack && !i_wbs_stb) begin
        o_wbs_ack <= 1'b0;
      end
      if (w_access) begin
        o_wbs_ack <= 1'b1;
      end

      if (w_write) begin
        case (i_wbs_adr)
          sdh_reg_pkg::CONTROL: begin
            r_control          <= i_wbs_dat;
            r_control.reserved <= '0;
          end
          sdh_reg_pkg::SD_ARGUMENT: begin
            r_cmd_arg <= i_wbs_dat;
          end
          sdh_reg_pkg::SD_COMMAND: begin
            r_command          <= i_wbs_dat;
            r_command.reserved <= '0;
          end
          sdh_reg_pkg::SD_CONFIGURE: begin
            r_crc_en <= i_wbs_dat[0];
          end
          sdh_reg_pkg::SD_DATA_BYTE_COUNT: begin
            r_byte_count <= i_wbs_dat[`SDH_BLK_W-1:0];
          end
          sdh_reg_pkg::SD_BLOCK_SLEEP: begin
            r_block_sleep <= i_wbs_dat;
          end
          sdh_reg_pkg::SD_DELAY_VALUE: begin
            r_delay_target <= i_wbs_dat[`SDH_DELAY_W-1:0];
          end
          default: begin
            if (w_blk_hit) begin
              r_blk_size[w_blk_idx] <= i_wbs_dat[`SDH_BLK_W-1:0];
            end
          end
        endcase
      end

      // Stack is done, drop the busy bits
      if (i_stack_stat.cmd_finished) begin
        r_command.go <= 1'b0;
      end
      if (i_stack_stat.data_finished) begin
        r_control.data_activate <= 1'b0;
      end
    end
  end

  // Held with ack until the next access
  always_ff @(posedge clk) begin
    if (w_read) begin
      o_wbs_dat <= w_rd_data;
    end
  end

  always_comb begin
    o_stack_req                 = '0;
    o_stack_req.cmd_en          = r_command.go;
    o_stack_req.cmd_index       = r_command.cmd_index;
    o_stack_req.cmd_arg         = r_cmd_arg;
    o_stack_req.cmd_long        = r_command.long_flag;
    o_stack_req.crc_en          = r_crc_en;
    o_stack_req.data_activate   = r_control.data_activate;
    o_stack_req.data_write      = r_control.data_write;
    o_stack_req.data_block_mode = r_control.data_block_mode;
    o_stack_req.func_addr       = r_control.func_addr;
    o_stack_req.byte_count      = r_byte_count;
    o_stack_req.block_sleep     = r_block_sleep;
    o_stack_req.block_size      = r_blk_size;
  end

  assign o_control      = r_control;
  assign o_delay_target = r_delay_target;

endmodule

/* sdh_irq_ctrl.sv */
module sdh_irq_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_wbs_stb,
  input  sdh_reg_pkg::control_t i_control,
  input  logic                  i_sd_int_detected,
  input  logic                  i_status_read,
  output logic                  o_wbs_int
);

  logic r_int_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_int_req <= 1'b0;
      o_wbs_int <= 1'b0;
    end else begin
      // Held off during bus traffic so a new edge can follow
      r_int_req <= i_sd_int_detected && !i_wbs_stb;

      if (!i_control.enable_interrupt) begin
        o_wbs_int <= 1'b0;
      end else if (r_int_req) begin
        o_wbs_int <= 1'b1;
      end else if (i_status_read) begin
        // Software has seen the status word
        o_wbs_int <= 1'b0;
      end
    end
  end

endmodule

/* sdh_delay_tuner.sv */
`include "sdh_settings.svh"

module sdh_delay_tuner (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`SDH_DELAY_W-1:0]    i_target,
  output sdh_stack_pkg::delay_step_t o_delay_step
);

  logic [`SDH_DELAY_W-1:0] r_current;

  // One tap per cycle so the PHY never jumps
  always_ff @(posedge clk) begin
    if (rst) begin
      r_current    <= `SDH_INITIAL_DELAY;
      o_delay_step <= '0;
    end else begin
      o_delay_step.en <= 1'b0;
      if (i_target > r_current) begin
        o_delay_step.en  <= 1'b1;
        o_delay_step.inc <= 1'b1;
        r_current        <= r_current + 1'b1;
      end else if (i_target < r_current) begin
        o_delay_step.en  <= 1'b1;
        o_delay_step.inc <= 1'b0;
        r_current        <= r_current - 1'b1;
      end
    end
  end

endmodule

/* sdh_host_top.sv */
`include "sdh_settings.svh"

module sdh_host_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_wbs_cyc,
  input  logic                        i_wbs_stb,
  input  logic                        i_wbs_we,
  input  logic [`SDH_ADR_W-1:0]       i_wbs_adr,
  input  logic [`SDH_DATA_W-1:0]      i_wbs_dat,
  input  sdh_stack_pkg::stack_stat_t  i_stack_stat,
  output logic                        o_wbs_ack,
  output logic [`SDH_DATA_W-1:0]      o_wbs_dat,
  output logic                        o_wbs_int,
  output sdh_stack_pkg::stack_req_t   o_stack_req,
  output sdh_stack_pkg::delay_step_t  o_delay_step
);

  sdh_reg_pkg::control_t   w_control;
  logic                    w_status_read;
  logic [`SDH_DELAY_W-1:0] w_delay_target;

  sdh_reg_file u_reg_file (
    .clk            (clk),
    .rst            (rst),
    .i_wbs_cyc      (i_wbs_cyc),
    .i_wbs_stb      (i_wbs_stb),
    .i_wbs_we       (i_wbs_we),
    .i_wbs_adr      (i_wbs_adr),
    .i_wbs_dat      (i_wbs_dat),
    .i_stack_stat   (i_stack_stat),
    .o_wbs_ack      (o_wbs_ack),
    .o_wbs_dat      (o_wbs_dat),
    .o_stack_req    (o_stack_req),
    .o_control      (w_control),
    .o_status_read  (w_status_read),
    .o_delay_target (w_delay_target)
  );

  sdh_irq_ctrl u_irq_ctrl (
    .clk               (clk),
    .rst               (rst),
    .i_wbs_stb         (i_wbs_stb),
    .i_control         (w_control),
    .i_sd_int_detected (i_stack_stat.int_detected),
    .i_status_read     (w_status_read),
    .o_wbs_int         (o_wbs_int)
  );

  // Drives the PHY delay line
  sdh_delay_tuner u_delay_tuner (
    .clk          (clk),
    .rst          (rst),
    .i_target     (w_delay_target),
    .o_delay_step (o_delay_step)
  );

endmodule

/* sdh_host_tb.sv */
`include "sdh_settings.svh"

module sdh_host_tb;

  localparam int MAX_OPS      = 96;
  localparam int ACK_TIMEOUT  = 20;
  localparam int STEP_TIMEOUT = 400;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       wbs_cyc;
  logic                       wbs_stb;
  logic                       wbs_we;
  logic [`SDH_ADR_W-1:0]      wbs_adr;
  logic [`SDH_DATA_W-1:0]     wbs_wdat;
  logic                       wbs_ack;
  logic [`SDH_DATA_W-1:0]     wbs_rdat;
  logic                       wbs_int;
  sdh_stack_pkg::stack_stat_t stack_stat;
  sdh_stack_pkg::stack_req_t  stack_req;
  sdh_stack_pkg::delay_step_t delay_step;

  // Op word and four argument words per operation
  logic [31:0] golden [0:5*MAX_OPS-1];
  logic [31:0] rng_state = 32'h70a83f92;
  int          up_count = 0;
  int          down_count = 0;
  int          up_base = 0;
  int          down_base = 0;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  logic        abort = 1'b0;

  sdh_host_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .i_wbs_cyc    (wbs_cyc),
    .i_wbs_stb    (wbs_stb),
    .i_wbs_we     (wbs_we),
    .i_wbs_adr    (wbs_adr),
    .i_wbs_dat    (wbs_wdat),
    .i_stack_stat (stack_stat),
    .o_wbs_ack    (wbs_ack),
    .o_wbs_dat    (wbs_rdat),
    .o_wbs_int    (wbs_int),
    .o_stack_req  (stack_req),
    .o_delay_step (delay_step)
  );

  always #5 clk = ~clk;

  // Tap steps as the PHY delay line sees them
  always @(posedge clk) begin
    if (!rst && delay_step.en === 1'b1) begin
      if (delay_step.inc) begin
        up_count <= up_count + 1;
      end else begin
        down_count <= down_count + 1;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] req_field(input logic [31:0] sel);
    logic [31:0] val;
    val = '0;
    case (sel)
      32'h00: val = 32'(stack_req.cmd_en);
      32'h01: val = 32'(stack_req.cmd_index);
      32'h02: val = stack_req.cmd_arg;
      32'h03: val = 32'(stack_req.cmd_long);
      32'h04: val = 32'(stack_req.data_activate);
      32'h05: val = 32'(stack_req.byte_count);
      32'h06: val = stack_req.block_sleep;
      32'h10: val = 32'(stack_req.func_addr);
      default: begin
        // Block sizes 0 to 8 sit at selectors 7 to f
        if (sel >= 32'h07 && sel <= 32'h0f) begin
          val = 32'(stack_req.block_size[sel[3:0] - 4'd7]);
        end
      end
    endcase
    return val;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Control and configure bits that go straight to the stack
  task automatic check_req_bits(input logic [31:0] adr, input logic [31:0] dat);
    sdh_reg_pkg::control_t ctrl;
    ctrl = dat;
    if (adr == sdh_reg_pkg::CONTROL) begin
      check_value("request data_write", 32'(stack_req.data_write), 32'(ctrl.data_write));
      check_value("request data_block_mode", 32'(stack_req.data_block_mode),
                  32'(ctrl.data_block_mode));
    end else if (adr == sdh_reg_pkg::SD_CONFIGURE) begin
      check_value("request crc_en", 32'(stack_req.crc_en), 32'(dat[0]));
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    abort = 1'b1;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, output logic [31:0] rdat);
    int cycles;
    wbs_cyc  = 1'b1;
    wbs_stb  = 1'b1;
    wbs_we   = we;
    wbs_adr  = adr;
    wbs_wdat = dat;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wbs_ack && cycles < ACK_TIMEOUT);
    if (!wbs_ack) begin
      note_timeout($sformatf("ack from address %h", adr));
    end
    rdat    = wbs_rdat;
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
    wbs_we  = 1'b0;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (wbs_ack && cycles < ACK_TIMEOUT);
    if (wbs_ack) begin
      note_timeout($sformatf("ack to drop at address %h", adr));
    end
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) @(negedge clk);
  endtask

  task automatic expect_int(input logic level);
    logic got;
    int   cycles;
    got = 1'b0;
    // Two cycles from the pulse and one spare
    for (cycles = 0; cycles < 3 && !got; cycles++) begin
      @(negedge clk);
      got = wbs_int;
    end
    check_value("interrupt level", 32'(got), 32'(level));
  endtask

  task automatic expect_steps(input int count, input logic up);
    int cycles;
    cycles = 0;
    while (up_count - up_base + down_count - down_base < count && cycles < STEP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (up_count - up_base + down_count - down_base < count) begin
      note_timeout("delay steps");
    end
    // Quiet cycles show that the tuner has settled
    repeat (4) @(negedge clk);
    check_value("delay steps up", 32'(up_count - up_base), up ? 32'(count) : 32'd0);
    check_value("delay steps down", 32'(down_count - down_base), up ? 32'd0 : 32'(count));
    up_base   = up_count;
    down_base = down_count;
  endtask

  task automatic run_op(input logic [31:0] op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] c, input logic [31:0] d);
    logic [31:0] rdat;
    case (op)
      32'h1: begin
        bus_access(1'b1, a, b, rdat);
        check_req_bits(a, b);
      end
      32'h2: begin
        bus_access(1'b0, a, '0, rdat);
        check_value($sformatf("read of address %h", a), rdat, b);
      end
      32'h3: begin
        stack_stat.ready = a[0];
        stack_stat.error = b[7:0];
      end
      32'h4: stack_stat.rsp = {a, b, c, d};
      32'h5, 32'h6, 32'h7: begin
        stack_stat.cmd_finished  = (op == 32'h5);
        stack_stat.data_finished = (op == 32'h6);
        stack_stat.int_detected  = (op == 32'h7);
        @(negedge clk);
        stack_stat.cmd_finished  = 1'b0;
        stack_stat.data_finished = 1'b0;
        stack_stat.int_detected  = 1'b0;
      end
      32'h8: expect_int(a[0]);
      32'h9: expect_steps(int'(a), b[0]);
      32'ha: check_value($sformatf("request field %h", a), req_field(a), b);
      default: begin
        errors++;
        $display("Unknown operation %h in the golden file", op);
      end
    endcase
  endtask

  initial begin
    logic [31:0] op;
    int          idx;
    rst        = 1'b1;
    wbs_cyc    = 1'b0;
    wbs_stb    = 1'b0;
    wbs_we     = 1'b0;
    wbs_adr    = '0;
    wbs_wdat   = '0;
    stack_stat = '0;
    for (idx = 0; idx < 5 * MAX_OPS; idx++) begin
      golden[idx] = '0;
    end
    $readmemh("sdh_golden.txt", golden);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (idx = 0; idx < MAX_OPS && !abort; idx++) begin
      op = golden[5*idx];
      if ($isunknown(op) || op == 32'h0) begin
        break;
      end
      run_op(op, golden[5*idx+1], golden[5*idx+2], golden[5*idx+3], golden[5*idx+4]);
    end
    if (idx == 0) begin
      errors++;
      $display("No operations could be read from sdh_golden.txt");
    end
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sdh_golden.txt */
// Columns op a b c d in hex. 1 write a=adr b=data, 2 read a=adr b=expected, 3 stack ready=a error=b
// 4 response a..d top word first, 5 cmd done, 6 data done, 7 irq pulse, 8 irq level a, 9 a steps up if b
// op a checks request field a (0 en 1 idx 2 arg 3 long 4 act 5 bytes 6 sleep 7-f blocks 10 func) = b
2 0e 1 0 0
2 22 10 0 0
1 06 deadbeef 0 0
2 06 deadbeef 0 0
1 08 3 0 0
2 08 1 0 0
1 0d ffffffff 0 0
2 0d ffffff 0 0
1 0e 12345678 0 0
2 0e 12345678 0 0
1 10 a5a5a5a5 0 0
2 10 a5a5a5 0 0
1 18 ff001000 0 0
2 18 1000 0 0
2 1f 0 0 0
2 02 0 0 0
a 5 ffffff 0 0
a 6 12345678 0 0
a 7 a5a5a5 0 0
a f 1000 0 0
4 01234567 89abcdef fedcba98 76543210
2 09 01234567 0 0
2 0a 89abcdef 0 0
2 0b fedcba98 0 0
2 0c 76543210 0 0
3 0 0 0 0
1 06 12340000 0 0
1 07 abcd00d1 0 0
a 0 1 0 0
a 1 11 0 0
a 2 12340000 0 0
a 3 1 0 0
2 01 2 0 0
2 07 d1 0 0
3 1 5a 0 0
5 0 0 0 0
a 0 0 0 0
2 01 5a8 0 0
2 07 51 0 0
1 00 ffffffa9 0 0
a 4 1 0 0
a 10 2 0 0
2 01 5ad 0 0
6 0 0 0 0
a 4 0 0 0
2 00 29 0 0
2 01 5a9 0 0
1 00 3 0 0
7 0 0 0 0
8 1 0 0 0
2 00 3 0 0
8 1 0 0 0
2 01 5a9 0 0
8 0 0 0 0
1 00 1 0 0
7 0 0 0 0
8 0 0 0 0
1 22 28 0 0
9 18 1 0 0
2 22 28 0 0
1 22 20 0 0
9 8 0 0 0
1 22 123 0 0
9 3 1 0 0
2 22 23 0 0
0 0 0 0 0

/* project.f */
+incdir+.
sdh_reg_pkg.sv
sdh_stack_pkg.sv
sdh_reg_file.sv
sdh_irq_ctrl.sv
sdh_delay_tuner.sv
sdh_host_top.sv
sdh_host_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
if [ $? -ne 0 ]; then
  echo "Could not remove the old build directory"
  exit 1
fi
verilator --binary --timing --assert -Wno-fatal --top-module sdh_host_tb \
  -f project.f -Mdir obj_dir -o sdh_host_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi
./obj_dir/sdh_host_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
